//--- Bender.yml
package:
  name: fetch_jump_predictor

sources:
  - target: any(rtl, test)
    include_dirs:
      - design
    files:
      - design/fetch_jump_predictor_pkg.sv
      - design/branch_history_table.sv
      - design/jalr_target_buffer.sv
      - design/slot_decoder.sv
      - design/redirect_selector.sv
      - design/fetch_jump_predictor.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/fetch_jump_predictor_properties.sv
      - testbench/fetch_jump_predictor_tb.sv

//--- design/branch_history_table.sv
`timescale 1ns/1ps
`include "fetch_jump_predictor_config.svh"

module branch_history_table (
	input  logic clk,
	input  logic arst_n,

	input  fetch_jump_predictor_pkg::addr_t           fetch_pc,
	input  fetch_jump_predictor_pkg::resolve_update_t resolve [`RESOLVE_PORTS],

	output fetch_jump_predictor_pkg::counter_t        counters [`FETCH_WIDTH]
);

	localparam int unsigned IDX_BITS = $clog2(`BHT_ENTRIES);

	fetch_jump_predictor_pkg::counter_t cnt_q [`BHT_ENTRIES];

	// Word-aligned index, PC bits 6..2 with the default size
	function automatic logic [IDX_BITS-1:0] bht_index(input fetch_jump_predictor_pkg::addr_t pc);
		return pc[IDX_BITS+1:2];
	endfunction

	// Saturating step toward the outcome
	function automatic fetch_jump_predictor_pkg::counter_t next_count(
		input fetch_jump_predictor_pkg::counter_t cnt,
		input logic                               taken
	);
		fetch_jump_predictor_pkg::counter_t res;
		res = cnt;
		if (taken && cnt != 2'b11)
			res = cnt + 2'd1;
		else if (!taken && cnt != 2'b00)
			res = cnt - 2'd1;
		return res;
	endfunction

	//////////////////////////////////////////////////
	// Lookup, one per slot
	//////////////////////////////////////////////////

	for (genvar s = 0; s < `FETCH_WIDTH; s++) begin : g_lookup
		fetch_jump_predictor_pkg::addr_t slot_pc;

		assign slot_pc     = fetch_pc + fetch_jump_predictor_pkg::addr_t'(4 * s);
		assign counters[s] = cnt_q[bht_index(slot_pc)]; // Old value during a write
	end

	//////////////////////////////////////////////////
	// Training
	//////////////////////////////////////////////////

	// Every port steps from the old value; the last assignment in port order
	// survives, so the highest port wins on a shared index
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int e = 0; e < `BHT_ENTRIES; e++) begin
				cnt_q[e] <= 2'b01; // Weakly not taken
			end
		end else begin
			for (int p = 0; p < `RESOLVE_PORTS; p++) begin
				if (resolve[p].valid)
					cnt_q[bht_index(resolve[p].pc)] <=
						next_count(cnt_q[bht_index(resolve[p].pc)], resolve[p].taken);
			end
		end
	end

endmodule

//--- design/fetch_jump_predictor.sv
`timescale 1ns/1ps
`include "fetch_jump_predictor_config.svh"

module fetch_jump_predictor (
	input  logic clk,
	input  logic arst_n,

	// Fetch side
	input  logic                                       fetch_valid,
	input  fetch_jump_predictor_pkg::fetch_bundle_t    fetch,

	// Training from the back end
	input  fetch_jump_predictor_pkg::resolve_update_t  resolve [`RESOLVE_PORTS],
	input  fetch_jump_predictor_pkg::jalr_update_t     jalr_update,

	// Prediction, one cycle after the strobe
	output logic                                       pred_valid,
	output fetch_jump_predictor_pkg::jump_prediction_t pred
);

	fetch_jump_predictor_pkg::counter_t         counters   [`FETCH_WIDTH];
	fetch_jump_predictor_pkg::slot_mask_t       jtb_hit;
	fetch_jump_predictor_pkg::addr_t            jtb_target [`FETCH_WIDTH];
	fetch_jump_predictor_pkg::slot_prediction_t slot_preds [`FETCH_WIDTH];

	branch_history_table bht_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.fetch_pc (fetch.pc),
		.resolve  (resolve),
		.counters (counters)
	);

	jalr_target_buffer jtb_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.fetch_pc    (fetch.pc),
		.jalr_update (jalr_update),
		.jtb_hit     (jtb_hit),
		.jtb_target  (jtb_target)
	);

	for (genvar s = 0; s < `FETCH_WIDTH; s++) begin : g_slot
		slot_decoder #(.SLOT(s)) decoder_inst (
			.fetch_pc   (fetch.pc),
			.instr      (fetch.instr[s]),
			.counter    (counters[s]),
			.jtb_hit    (jtb_hit[s]),
			.jtb_target (jtb_target[s]),
			.slot_pred  (slot_preds[s])
		);
	end

	redirect_selector selector_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.fetch_valid (fetch_valid),
		.slot_preds  (slot_preds),
		.pred_valid  (pred_valid),
		.pred        (pred)
	);

endmodule

//--- design/fetch_jump_predictor_config.svh
`ifndef FETCH_JUMP_PREDICTOR_CONFIG_SVH
`define FETCH_JUMP_PREDICTOR_CONFIG_SVH

//////////////////////////////////////////////////
// Fetch geometry
//////////////////////////////////////////////////

// Instructions per aligned fetch bundle
`define FETCH_WIDTH 5

// Address and instruction width, RV32I
`define XLEN 32

//////////////////////////////////////////////////
// Predictor tables
//////////////////////////////////////////////////

// 2-bit counters, indexed by slot PC bits 6..2
`define BHT_ENTRIES 32

// JALR targets, indexed by PC bits 5..2, tag is the rest above
`define JTB_ENTRIES 16

// Branch resolve ports from the back end
`define RESOLVE_PORTS 3

`endif

//--- design/fetch_jump_predictor_pkg.sv
`include "fetch_jump_predictor_config.svh"

package fetch_jump_predictor_pkg;

	//////////////////////////////////////////////////
	// Widths with a meaning
	//////////////////////////////////////////////////

	typedef logic [`XLEN-1:0]        addr_t;
	typedef logic [`XLEN-1:0]        instr_t;
	typedef logic [1:0]              counter_t;   // High bit set means taken
	typedef logic [2:0]              slot_idx_t;
	typedef logic [`FETCH_WIDTH-1:0] slot_mask_t; // One bit per slot

	// RV32I control transfer opcodes, bits 6..0
	typedef enum logic [6:0] {
		op_branch = 7'b1100011,
		op_jalr   = 7'b1100111,
		op_jal    = 7'b1101111
	} opcode_e;

	typedef enum logic [1:0] {
		cls_other,
		cls_jal,
		cls_branch,
		cls_jalr
	} jump_class_e;

	//////////////////////////////////////////////////
	// Bundles and update records
	//////////////////////////////////////////////////

	typedef struct packed {
		addr_t                        pc;    // Start PC, slot 0
		instr_t [`FETCH_WIDTH-1:0]    instr;
	} fetch_bundle_t;

	typedef struct packed {
		logic  valid;
		addr_t pc;
		logic  taken; // Actual outcome
	} resolve_update_t;

	typedef struct packed {
		logic  valid;
		addr_t pc;
		addr_t target;
	} jalr_update_t;

	typedef struct packed {
		jump_class_e jump_class;
		logic        redirect;
		addr_t       target;
	} slot_prediction_t;

	typedef struct packed {
		logic       redirect;
		slot_idx_t  redirect_slot;
		addr_t      redirect_target;
		slot_mask_t jump_mask;
		slot_mask_t jalr_mask;
	} jump_prediction_t;

endpackage

//--- design/jalr_target_buffer.sv
`timescale 1ns/1ps
`include "fetch_jump_predictor_config.svh"

module jalr_target_buffer (
	input  logic clk,
	input  logic arst_n,

	input  fetch_jump_predictor_pkg::addr_t        fetch_pc,
	input  fetch_jump_predictor_pkg::jalr_update_t jalr_update,

	output fetch_jump_predictor_pkg::slot_mask_t   jtb_hit,
	output fetch_jump_predictor_pkg::addr_t        jtb_target [`FETCH_WIDTH]
);

	localparam int unsigned IDX_BITS = $clog2(`JTB_ENTRIES);
	localparam int unsigned TAG_BITS = `XLEN - IDX_BITS - 2;

	typedef logic [IDX_BITS-1:0] jtb_idx_t;
	typedef logic [TAG_BITS-1:0] jtb_tag_t;

	logic                            valid_q  [`JTB_ENTRIES];
	jtb_tag_t                        tag_q    [`JTB_ENTRIES];
	fetch_jump_predictor_pkg::addr_t target_q [`JTB_ENTRIES];

	jtb_idx_t upd_idx;
	jtb_tag_t upd_tag;

	assign upd_idx = jalr_update.pc[IDX_BITS+1:2];
	assign upd_tag = jalr_update.pc[`XLEN-1:IDX_BITS+2];

	//////////////////////////////////////////////////
	// Per-slot lookup
	//////////////////////////////////////////////////

	for (genvar s = 0; s < `FETCH_WIDTH; s++) begin : g_lookup
		fetch_jump_predictor_pkg::addr_t slot_pc;
		jtb_idx_t                        slot_idx;
		jtb_tag_t                        slot_tag;

		assign slot_pc  = fetch_pc + fetch_jump_predictor_pkg::addr_t'(4 * s);
		assign slot_idx = slot_pc[IDX_BITS+1:2];
		assign slot_tag = slot_pc[`XLEN-1:IDX_BITS+2];

		// Same index with another tag is a miss
		assign jtb_hit[s]    = valid_q[slot_idx] && (tag_q[slot_idx] == slot_tag);
		assign jtb_target[s] = target_q[slot_idx];
	end

	//////////////////////////////////////////////////
	// Update
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int e = 0; e < `JTB_ENTRIES; e++) begin
				valid_q[e] <= 1'b0;
			end
		end else if (jalr_update.valid) begin
			valid_q[upd_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (jalr_update.valid) begin // Direct mapped, plain overwrite
			tag_q[upd_idx]    <= upd_tag;
			target_q[upd_idx] <= jalr_update.target;
		end
	end

endmodule

//--- design/redirect_selector.sv
`timescale 1ns/1ps
`include "fetch_jump_predictor_config.svh"

module redirect_selector (
	input  logic clk,
	input  logic arst_n,

	input  logic                                       fetch_valid,
	input  fetch_jump_predictor_pkg::slot_prediction_t slot_preds [`FETCH_WIDTH],

	output logic                                       pred_valid,
	output fetch_jump_predictor_pkg::jump_prediction_t pred
);

	fetch_jump_predictor_pkg::jump_prediction_t pred_d;

	//////////////////////////////////////////////////
	// Masks and first redirect
	//////////////////////////////////////////////////

	// Walk from the last slot down so the lowest redirecting slot is kept
	always_comb begin
		pred_d = '0; // Slot and target stay zero without a redirect
		for (int s = `FETCH_WIDTH - 1; s >= 0; s--) begin
			pred_d.jalr_mask[s] = (slot_preds[s].jump_class == fetch_jump_predictor_pkg::cls_jalr);

			// JAL always, branch only when predicted taken
			pred_d.jump_mask[s] = slot_preds[s].redirect &&
				(slot_preds[s].jump_class == fetch_jump_predictor_pkg::cls_jal ||
				 slot_preds[s].jump_class == fetch_jump_predictor_pkg::cls_branch);

			if (slot_preds[s].redirect) begin
				pred_d.redirect        = 1'b1;
				pred_d.redirect_slot   = fetch_jump_predictor_pkg::slot_idx_t'(s);
				pred_d.redirect_target = slot_preds[s].target;
			end
		end
	end

	//////////////////////////////////////////////////
	// Output stage
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pred_valid <= 1'b0;
			pred       <= '0;
		end else begin
			pred_valid <= fetch_valid; // One-cycle pulse per strobe
			if (fetch_valid)
				pred <= pred_d; // Held until the next bundle
		end
	end

endmodule

//--- design/slot_decoder.sv
`timescale 1ns/1ps
`include "fetch_jump_predictor_config.svh"

module slot_decoder #(
	parameter int unsigned SLOT = 0 // Position in the bundle
) (
	input  fetch_jump_predictor_pkg::addr_t            fetch_pc,
	input  fetch_jump_predictor_pkg::instr_t           instr,
	input  fetch_jump_predictor_pkg::counter_t         counter,
	input  logic                                       jtb_hit,
	input  fetch_jump_predictor_pkg::addr_t            jtb_target,
	output fetch_jump_predictor_pkg::slot_prediction_t slot_pred
);

	fetch_jump_predictor_pkg::addr_t       slot_pc;
	fetch_jump_predictor_pkg::addr_t       imm_j;
	fetch_jump_predictor_pkg::addr_t       imm_b;
	fetch_jump_predictor_pkg::jump_class_e jump_class;

	assign slot_pc = fetch_pc + fetch_jump_predictor_pkg::addr_t'(4 * SLOT);

	// J and B immediates, bit 0 always zero
	assign imm_j = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_b = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

	//////////////////////////////////////////////////
	// Opcode class
	//////////////////////////////////////////////////

	always_comb begin
		case (instr[6:0])
			fetch_jump_predictor_pkg::op_jal:    jump_class = fetch_jump_predictor_pkg::cls_jal;
			fetch_jump_predictor_pkg::op_branch: jump_class = fetch_jump_predictor_pkg::cls_branch;
			fetch_jump_predictor_pkg::op_jalr:   jump_class = fetch_jump_predictor_pkg::cls_jalr;
			default:                             jump_class = fetch_jump_predictor_pkg::cls_other;
		endcase
	end

	//////////////////////////////////////////////////
	// Decision and target
	//////////////////////////////////////////////////

	always_comb begin
		slot_pred.jump_class = jump_class;
		case (jump_class)
			fetch_jump_predictor_pkg::cls_jal: begin
				slot_pred.redirect = 1'b1; // Unconditional
				slot_pred.target   = slot_pc + imm_j;
			end
			fetch_jump_predictor_pkg::cls_branch: begin
				slot_pred.redirect = counter[1];
				slot_pred.target   = slot_pc + imm_b;
			end
			fetch_jump_predictor_pkg::cls_jalr: begin
				slot_pred.redirect = jtb_hit; // Only a known target redirects
				slot_pred.target   = jtb_target;
			end
			default: begin
				slot_pred.redirect = 1'b0;
				slot_pred.target   = '0;
			end
		endcase
	end

endmodule

//--- fetch_jump_predictor.f
+incdir+design
design/fetch_jump_predictor_pkg.sv
design/branch_history_table.sv
design/jalr_target_buffer.sv
design/slot_decoder.sv
design/redirect_selector.sv
design/fetch_jump_predictor.sv
testbench/fetch_jump_predictor_properties.sv
testbench/fetch_jump_predictor_tb.sv

//--- testbench/fetch_jump_predictor_properties.sv
`timescale 1ns/1ps

module fetch_jump_predictor_properties (
	input logic                                       clk,
	input logic                                       arst_n,
	input logic                                       fetch_valid,
	input logic                                       pred_valid,
	input fetch_jump_predictor_pkg::jump_prediction_t pred
);

	// Every strobe answers on the next edge
	strobe_answered: assert property (@(posedge clk) disable iff (!arst_n)
		fetch_valid |=> pred_valid)
		else $error("pred_valid missing one cycle after fetch_valid");

	// Two valid cycles in a row need two strobes
	no_stretched_valid: assert property (@(posedge clk) disable iff (!arst_n)
		pred_valid ##1 pred_valid |-> $past(fetch_valid, 1) && $past(fetch_valid, 2))
		else $error("pred_valid held high without back-to-back strobes");

	idle_fields_zero: assert property (@(posedge clk) disable iff (!arst_n)
		!pred.redirect |-> pred.redirect_slot == '0 && pred.redirect_target == '0)
		else $error("redirect slot or target nonzero without a redirect");

endmodule

bind fetch_jump_predictor fetch_jump_predictor_properties props0 (
	.clk         (clk),
	.arst_n      (arst_n),
	.fetch_valid (fetch_valid),
	.pred_valid  (pred_valid),
	.pred        (pred)
);

//--- testbench/fetch_jump_predictor_tb.sv
`timescale 1ns/1ps
`include "fetch_jump_predictor_config.svh"

module fetch_jump_predictor_tb;

	localparam int TIMEOUT_CYCLES = 20;
	localparam int BHT_BITS       = $clog2(`BHT_ENTRIES);
	localparam int JTB_BITS       = $clog2(`JTB_ENTRIES);

	logic                                       clk;
	logic                                       arst_n;
	logic                                       fetch_valid;
	fetch_jump_predictor_pkg::fetch_bundle_t    fetch;
	fetch_jump_predictor_pkg::resolve_update_t  resolve      [`RESOLVE_PORTS];
	fetch_jump_predictor_pkg::jalr_update_t     jalr_update;
	logic                                       pred_valid;
	fetch_jump_predictor_pkg::jump_prediction_t pred;

	// Updates queued for the next driven cycle
	fetch_jump_predictor_pkg::resolve_update_t  resolve_next [`RESOLVE_PORTS];
	fetch_jump_predictor_pkg::jalr_update_t     jalr_next;

	// Shadow predictor state
	fetch_jump_predictor_pkg::counter_t         bht_model    [`BHT_ENTRIES];
	logic                                       jtb_valid    [`JTB_ENTRIES];
	fetch_jump_predictor_pkg::addr_t            jtb_pc       [`JTB_ENTRIES]; // Full PC holds the tag
	fetch_jump_predictor_pkg::addr_t            jtb_dest     [`JTB_ENTRIES];

	fetch_jump_predictor_pkg::jump_prediction_t exp_q [$];
	int                                         mismatch_count;
	int                                         failure_count;
	logic [31:0]                                lcg_state;

	fetch_jump_predictor dut0 (
		.clk         (clk),
		.arst_n      (arst_n),
		.fetch_valid (fetch_valid),
		.fetch       (fetch),
		.resolve     (resolve),
		.jalr_update (jalr_update),
		.pred_valid  (pred_valid),
		.pred        (pred)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic fetch_jump_predictor_pkg::instr_t rand_instr(
		input fetch_jump_predictor_pkg::jump_class_e cls
	);
		logic [31:0] r;
		r = lcg_next();
		case (cls)
			fetch_jump_predictor_pkg::cls_jal:    return {r[31:7], 7'b1101111};
			fetch_jump_predictor_pkg::cls_branch: return {r[31:7], 7'b1100011};
			fetch_jump_predictor_pkg::cls_jalr:   return {r[31:7], 7'b1100111};
			default:                              return {r[31:7], r[20] ? 7'b0010011 : 7'b0110011};
		endcase
	endfunction

	function automatic fetch_jump_predictor_pkg::fetch_bundle_t plain_bundle(input logic [31:0] pc);
		fetch_jump_predictor_pkg::fetch_bundle_t b;
		b.pc = pc;
		for (int s = 0; s < `FETCH_WIDTH; s++)
			b.instr[s] = rand_instr(fetch_jump_predictor_pkg::cls_other);
		return b;
	endfunction

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic fetch_jump_predictor_pkg::jump_prediction_t predict(
		input fetch_jump_predictor_pkg::fetch_bundle_t b
	);
		fetch_jump_predictor_pkg::jump_prediction_t p;
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] dest;
		logic        taken;
		int          e;
		p = '0;
		for (int s = 0; s < `FETCH_WIDTH; s++) begin
			pc    = b.pc + 4 * s;
			ins   = b.instr[s];
			taken = 1'b0;
			dest  = '0;
			case (ins[6:0])
				7'b1101111: begin // JAL with a J immediate
					taken = 1'b1;
					dest  = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
					p.jump_mask[s] = 1'b1;
				end
				7'b1100011: begin // Branch with a B immediate
					taken = bht_model[pc[BHT_BITS+1:2]][1];
					dest  = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
					p.jump_mask[s] = taken;
				end
				7'b1100111: begin
					e     = pc[JTB_BITS+1:2];
					taken = jtb_valid[e] && jtb_pc[e][31:JTB_BITS+2] == pc[31:JTB_BITS+2];
					dest  = jtb_dest[e];
					p.jalr_mask[s] = 1'b1;
				end
				default: ;
			endcase
			if (taken && !p.redirect) begin // First in program order
				p.redirect        = 1'b1;
				p.redirect_slot   = fetch_jump_predictor_pkg::slot_idx_t'(s);
				p.redirect_target = dest;
			end
		end
		return p;
	endfunction

	// Ports step from the old counter and a later port overwrites
	task automatic train_model();
		fetch_jump_predictor_pkg::counter_t old [`BHT_ENTRIES];
		fetch_jump_predictor_pkg::counter_t cnt;
		int idx;
		old = bht_model;
		for (int p = 0; p < `RESOLVE_PORTS; p++) begin
			if (resolve_next[p].valid) begin
				idx = resolve_next[p].pc[BHT_BITS+1:2];
				cnt = old[idx];
				if (resolve_next[p].taken)
					bht_model[idx] = (cnt == 2'b11) ? cnt : cnt + 2'd1;
				else
					bht_model[idx] = (cnt == 2'b00) ? cnt : cnt - 2'd1;
			end
		end
		if (jalr_next.valid) begin
			idx = jalr_next.pc[JTB_BITS+1:2];
			jtb_valid[idx] = 1'b1;
			jtb_pc[idx]    = jalr_next.pc;
			jtb_dest[idx]  = jalr_next.target;
		end
	endtask

	task automatic set_resolve(input int port, input logic [31:0] pc, input logic taken);
		resolve_next[port] = '{valid: 1'b1, pc: pc, taken: taken};
	endtask

	task automatic set_jalr(input logic [31:0] pc, input logic [31:0] target);
		jalr_next = '{valid: 1'b1, pc: pc, target: target};
	endtask

	// One falling edge of drive; lookup uses the state before this cycle's updates
	task automatic step(input logic strobe, input fetch_jump_predictor_pkg::fetch_bundle_t b);
		@(negedge clk);
		fetch_valid = strobe;
		fetch       = b;
		resolve     = resolve_next;
		jalr_update = jalr_next;
		if (strobe)
			exp_q.push_back(predict(b));
		train_model();
		for (int p = 0; p < `RESOLVE_PORTS; p++)
			resolve_next[p] = '0;
		jalr_next = '0;
	endtask

	task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] want);
		assert (got === want) else begin
			mismatch_count++;
			$display("mismatch %s: got %h expected %h", name, got, want);
		end
	endtask

	task automatic finish_run();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	//////////////////////////////////////////////////
	// Checker
	//////////////////////////////////////////////////

	initial begin : compare_process
		fetch_jump_predictor_pkg::jump_prediction_t want;
		int   waited;
		logic timed_out;
		waited    = 0;
		timed_out = 1'b0;
		while (!timed_out) begin
			@(negedge clk);
			if (pred_valid === 1'b1) begin
				waited = 0;
				assert (exp_q.size() != 0) else begin
					failure_count++;
					$display("pred_valid went high with no bundle outstanding");
				end
				if (exp_q.size() != 0) begin
					want = exp_q.pop_front();
					check_field("redirect", 32'(pred.redirect), 32'(want.redirect));
					check_field("redirect_slot", 32'(pred.redirect_slot), 32'(want.redirect_slot));
					check_field("redirect_target", pred.redirect_target, want.redirect_target);
					check_field("jump_mask", 32'(pred.jump_mask), 32'(want.jump_mask));
					check_field("jalr_mask", 32'(pred.jalr_mask), 32'(want.jalr_mask));
				end
			end else if (exp_q.size() != 0) begin
				waited++;
				assert (waited <= TIMEOUT_CYCLES) else begin
					failure_count++;
					$display("no prediction arrived within %0d cycles of a strobe", TIMEOUT_CYCLES);
					timed_out = 1'b1;
				end
			end else begin
				waited = 0;
			end
		end
		finish_run();
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin : stimulus
		fetch_jump_predictor_pkg::fetch_bundle_t b;
		logic [31:0] r;
		int          waited;
		lcg_state      = 32'd89;
		mismatch_count = 0;
		failure_count  = 0;
		arst_n         = 1'b0;
		fetch_valid    = 1'b0;
		fetch          = '0;
		jalr_update    = '0;
		jalr_next      = '0;
		for (int p = 0; p < `RESOLVE_PORTS; p++) begin
			resolve[p]      = '0;
			resolve_next[p] = '0;
		end
		for (int e = 0; e < `BHT_ENTRIES; e++)
			bht_model[e] = 2'b01; // Weakly not taken
		for (int e = 0; e < `JTB_ENTRIES; e++)
			jtb_valid[e] = 1'b0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;

		// Only branches with nothing trained yet
		b = plain_bundle(32'h0000_1000);
		for (int s = 0; s < `FETCH_WIDTH; s++)
			b.instr[s] = rand_instr(fetch_jump_predictor_pkg::cls_branch);
		step(1'b1, b);

		// JAL behind a not-taken branch and a second JAL shadowed
		b = plain_bundle(32'h0000_2040);
		b.instr[1] = rand_instr(fetch_jump_predictor_pkg::cls_branch);
		b.instr[3] = rand_instr(fetch_jump_predictor_pkg::cls_jal);
		b.instr[4] = rand_instr(fetch_jump_predictor_pkg::cls_jal);
		step(1'b1, b);

		// Train slot 2 up to saturation, then back down past zero
		b = plain_bundle(32'h0000_3000);
		b.instr[2] = rand_instr(fetch_jump_predictor_pkg::cls_branch);
		b.instr[4] = rand_instr(fetch_jump_predictor_pkg::cls_jal);
		repeat (4) begin
			set_resolve(0, 32'h0000_3008, 1'b1);
			step(1'b1, b); // Lookup sees the pre-update counter
		end
		repeat (5) begin
			set_resolve(2, 32'h0000_3008, 1'b0);
			step(1'b1, b);
		end
		step(1'b1, b);

		// JALR learns its target, then an aliased PC misses on the tag
		b = plain_bundle(32'h0000_4010);
		b.instr[1] = rand_instr(fetch_jump_predictor_pkg::cls_jalr);
		b.instr[3] = rand_instr(fetch_jump_predictor_pkg::cls_jal);
		step(1'b1, b);
		set_jalr(32'h0000_4014, 32'h0000_8800);
		step(1'b1, b);
		step(1'b1, b);
		b.pc = 32'h0000_4050;
		step(1'b1, b);

		// Three ports on one index where the highest port decides
		b = plain_bundle(32'h0000_5000);
		b.instr[0] = rand_instr(fetch_jump_predictor_pkg::cls_branch);
		set_resolve(1, 32'h0000_5000, 1'b1);
		step(1'b1, b);
		set_resolve(0, 32'h0000_5000, 1'b1);
		set_resolve(2, 32'h0000_5080, 1'b0); // Aliases index 0
		step(1'b1, b);
		set_resolve(0, 32'h0000_5000, 1'b0);
		set_resolve(1, 32'h0000_5000, 1'b1);
		step(1'b1, b);
		step(1'b1, b);

		// Random mixes with training in flight
		repeat (80) begin
			r    = lcg_next();
			b.pc = 32'h0000_6000 | {22'd0, r[29:22], 2'b00};
			for (int s = 0; s < `FETCH_WIDTH; s++) begin
				r          = lcg_next();
				b.instr[s] = rand_instr(fetch_jump_predictor_pkg::jump_class_e'(r[31:30]));
			end
			for (int p = 0; p < `RESOLVE_PORTS; p++) begin
				r = lcg_next();
				if (r[20])
					set_resolve(p, 32'h0000_6000 | {22'd0, r[29:22], 2'b00}, r[30]);
			end
			r = lcg_next();
			if (r[19:18] == 2'b00)
				set_jalr(32'h0000_6000 | {22'd0, r[29:22], 2'b00}, lcg_next() & 32'hFFFF_FFFC);
			step(r[17:16] != 2'b00, b);
		end
		step(1'b0, b);

		waited = 0;
		while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		assert (exp_q.size() == 0) else begin
			failure_count++;
			$display("%0d predictions still outstanding at the end", exp_q.size());
		end
		finish_run();
	end

endmodule
